//--- design/wb_pkg.sv
/* shared types for the write buffer. lines are 2**OFFSET_WIDTH words, 1 <= OFFSET_WIDTH <= 8,
   and every burst is INCR with 32-bit beats */
`default_nettype none

package wb_pkg;

    // byte address of a cache line
    typedef logic [31:0] addr_t;

    // one AXI data beat
    typedef logic [31:0] word_t;

    // AW channel payload
    typedef struct packed {
        addr_t      addr;
        // beats minus one
        logic [7:0] len;
    } axi_aw_t;

    // W channel payload
    typedef struct packed {
        word_t data;
        logic  last;
    } axi_w_t;

    // AXI len field for one full line
    function automatic logic [7:0] burst_len(input int unsigned offset_width);
        int unsigned beats;
        beats = 1 << offset_width;
        return 8'(beats - 1);
    endfunction

endpackage

`default_nettype wire

//--- design/wb_queue.sv
/* line queue of DEPTH >= 2 entries. index 0 is the newest entry and count-1 the oldest.
   a pop on an empty queue is ignored, and the caller keeps pushes within in_ready */
`default_nettype none

module wb_queue #(
    parameter int DEPTH        = 5,
    parameter int OFFSET_WIDTH = 3
) (
    input  wire logic                                clk,
    input  wire logic                                rstn,
    input  wire logic                                in_valid,
    input  wire wb_pkg::addr_t                       in_addr,
    input  wire logic [32*(2**OFFSET_WIDTH)-1:0]     in_line,
    output logic                                     in_ready,
    input  wire logic                                pop,
    output logic                                     head_valid,
    output wb_pkg::addr_t                            head_addr,
    output logic [32*(2**OFFSET_WIDTH)-1:0]          head_line,
    input  wire wb_pkg::addr_t                       query_addr,
    output logic                                     query_hit,
    output logic [32*(2**OFFSET_WIDTH)-1:0]          query_line
);
    import wb_pkg::*;

    localparam int LINE_W = 32 * (2 ** OFFSET_WIDTH);
    localparam int CNT_W  = $clog2(DEPTH + 1);

    addr_t               ent_addr [DEPTH];
    logic [LINE_W-1:0]   ent_line [DEPTH];
    logic [DEPTH-1:0]    valid_q;
    logic [DEPTH-1:0]    valid_nxt;
    logic [CNT_W-1:0]    count_q;
    logic [CNT_W-1:0]    head_idx;
    logic                push;
    logic                pop_ok;
    logic [DEPTH-1:0]    hit_vec;

    assign in_ready = (count_q < CNT_W'(DEPTH));
    assign push     = in_valid && in_ready;
    assign pop_ok   = pop && (count_q != '0);

    // oldest entry sits at count-1
    assign head_idx   = (count_q == '0) ? '0 : count_q - 1'b1;
    assign head_valid = (count_q != '0);
    assign head_addr  = ent_addr[head_idx];
    assign head_line  = ent_line[head_idx];

    // shift toward higher indices, new line lands at 0
    always_ff @(posedge clk) begin
        if (push) begin
            ent_addr[0] <= in_addr;
            ent_line[0] <= in_line;
            for (int i = 1; i < DEPTH; i++) begin
                ent_addr[i] <= ent_addr[i-1];
                ent_line[i] <= ent_line[i-1];
            end
        end
    end

    always_comb begin
        valid_nxt = valid_q;
        if (push) begin
            valid_nxt = {valid_q[DEPTH-2:0], 1'b1};
        end
        // with a push in the same cycle the head has already moved up one slot
        if (pop_ok) begin
            if (push) begin
                valid_nxt[count_q] = 1'b0;
            end else begin
                valid_nxt[head_idx] = 1'b0;
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid_q <= '0;
            count_q <= '0;
        end else begin
            valid_q <= valid_nxt;
            case ({push, pop_ok})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // address compare on live entries only
    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            hit_vec[i] = valid_q[i] && (ent_addr[i] == query_addr);
        end
    end

    // scan from the oldest so index 0 wins, newest match
    always_comb begin
        query_hit  = 1'b0;
        query_line = '0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (hit_vec[i]) begin
                query_hit  = 1'b1;
                query_line = ent_line[i];
            end
        end
    end

endmodule

`default_nettype wire

//--- design/wb_drain_ctrl.sv
/* one drain at a time. dma_lock is only sampled when leaving idle,
   a drain that has started runs to its write response */
`default_nettype none

module wb_drain_ctrl #(
    parameter int OFFSET_WIDTH = 3
) (
    input  wire logic                                clk,
    input  wire logic                                rstn,
    input  wire logic                                head_valid,
    input  wire wb_pkg::addr_t                       head_addr,
    input  wire logic [32*(2**OFFSET_WIDTH)-1:0]     head_line,
    output logic                                     pop,
    input  wire logic                                dma_lock,
    output logic                                     wrt_lock,
    output wb_pkg::axi_aw_t                          aw,
    output logic                                     aw_valid,
    input  wire logic                                aw_ready,
    output logic                                     load,
    output logic [32*(2**OFFSET_WIDTH)-1:0]          line,
    input  wire logic                                burst_done,
    input  wire logic                                b_valid,
    output logic                                     b_ready
);
    import wb_pkg::*;

    localparam int LINE_W = 32 * (2 ** OFFSET_WIDTH);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ADDR,
        ST_DATA,
        ST_RESP
    } state_t;

    state_t            state_q;
    state_t            state_nxt;
    addr_t             addr_q;
    logic [LINE_W-1:0] line_q;
    logic              start;

    assign start = (state_q == ST_IDLE) && head_valid && !dma_lock;

    always_comb begin
        state_nxt = state_q;
        case (state_q)
            ST_IDLE: begin
                if (start) begin
                    state_nxt = ST_ADDR;
                end
            end
            ST_ADDR: begin
                if (aw_ready) begin
                    state_nxt = ST_DATA;
                end
            end
            ST_DATA: begin
                if (burst_done) begin
                    state_nxt = ST_RESP;
                end
            end
            ST_RESP: begin
                if (b_valid) begin
                    state_nxt = ST_IDLE;
                end
            end
            default: state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_nxt;
        end
    end

    // snapshot of the head, queue may shift below us
    always_ff @(posedge clk) begin
        if (start) begin
            addr_q <= head_addr;
            line_q <= head_line;
        end
    end

    assign aw_valid = (state_q == ST_ADDR);
    assign aw       = '{addr: addr_q, len: burst_len(OFFSET_WIDTH)};
    assign load     = aw_valid && aw_ready;
    assign line     = line_q;
    assign b_ready  = (state_q == ST_RESP);

    // entry leaves the queue only once memory has it
    assign pop      = b_ready && b_valid;
    assign wrt_lock = (state_q != ST_IDLE);

endmodule

`default_nettype wire

//--- design/wb_beat_serializer.sv
/* sends a loaded line as 2**OFFSET_WIDTH beats, low word first.
   a load while a burst is still active restarts it */
`default_nettype none

module wb_beat_serializer #(
    parameter int OFFSET_WIDTH = 3
) (
    input  wire logic                                clk,
    input  wire logic                                rstn,
    input  wire logic                                load,
    input  wire logic [32*(2**OFFSET_WIDTH)-1:0]     line,
    output wb_pkg::axi_w_t                           w,
    output logic                                     w_valid,
    input  wire logic                                w_ready,
    output logic                                     burst_done
);
    import wb_pkg::*;

    localparam int WORDS = 2 ** OFFSET_WIDTH;

    word_t [WORDS-1:0]       words_q;
    logic [OFFSET_WIDTH-1:0] beat_q;
    logic                    valid_q;
    logic                    last;
    logic                    accept;

    assign last    = (beat_q == OFFSET_WIDTH'(WORDS - 1));
    assign accept  = valid_q && w_ready;
    assign w_valid = valid_q;
    assign w       = '{data: words_q[beat_q], last: last};

    // strobe on the handshake of the final beat
    assign burst_done = accept && last;

    always_ff @(posedge clk) begin
        if (load) begin
            words_q <= line;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid_q <= 1'b0;
            beat_q  <= '0;
        end else if (load) begin
            valid_q <= 1'b1;
            beat_q  <= '0;
        end else if (accept) begin
            if (last) begin
                valid_q <= 1'b0;
                beat_q  <= '0;
            end else begin
                beat_q <= beat_q + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- design/write_buffer.sv
/* write buffer between a write-back cache and an AXI write port, single outstanding burst.
   response codes are ignored and no IDs or strobes are driven */
`default_nettype none

module write_buffer #(
    parameter int DEPTH        = 5,
    parameter int OFFSET_WIDTH = 3
) (
    input  wire logic                                clk,
    input  wire logic                                rstn,
    // cache side
    input  wire logic                                in_valid,
    input  wire wb_pkg::addr_t                       in_addr,
    input  wire logic [32*(2**OFFSET_WIDTH)-1:0]     in_line,
    output logic                                     in_ready,
    // read miss lookup
    input  wire wb_pkg::addr_t                       query_addr,
    output logic                                     query_hit,
    output logic [32*(2**OFFSET_WIDTH)-1:0]          query_line,
    // DMA arbitration
    input  wire logic                                dma_lock,
    output logic                                     wrt_lock,
    // AXI write channels
    output wb_pkg::axi_aw_t                          aw,
    output logic                                     aw_valid,
    input  wire logic                                aw_ready,
    output wb_pkg::axi_w_t                           w,
    output logic                                     w_valid,
    input  wire logic                                w_ready,
    input  wire logic                                b_valid,
    output logic                                     b_ready
);
    import wb_pkg::*;

    localparam int LINE_W = 32 * (2 ** OFFSET_WIDTH);

    logic              head_valid;
    addr_t             head_addr;
    logic [LINE_W-1:0] head_line;
    logic              pop;
    logic              load;
    logic [LINE_W-1:0] drain_line;
    logic              burst_done;

    wb_queue #(
        .DEPTH       (DEPTH),
        .OFFSET_WIDTH(OFFSET_WIDTH)
    ) wb_queue_i (
        .clk       (clk),
        .rstn      (rstn),
        .in_valid  (in_valid),
        .in_addr   (in_addr),
        .in_line   (in_line),
        .in_ready  (in_ready),
        .pop       (pop),
        .head_valid(head_valid),
        .head_addr (head_addr),
        .head_line (head_line),
        .query_addr(query_addr),
        .query_hit (query_hit),
        .query_line(query_line)
    );

    wb_drain_ctrl #(
        .OFFSET_WIDTH(OFFSET_WIDTH)
    ) wb_drain_ctrl_i (
        .clk       (clk),
        .rstn      (rstn),
        .head_valid(head_valid),
        .head_addr (head_addr),
        .head_line (head_line),
        .pop       (pop),
        .dma_lock  (dma_lock),
        .wrt_lock  (wrt_lock),
        .aw        (aw),
        .aw_valid  (aw_valid),
        .aw_ready  (aw_ready),
        .load      (load),
        .line      (drain_line),
        .burst_done(burst_done),
        .b_valid   (b_valid),
        .b_ready   (b_ready)
    );

    wb_beat_serializer #(
        .OFFSET_WIDTH(OFFSET_WIDTH)
    ) wb_beat_serializer_i (
        .clk       (clk),
        .rstn      (rstn),
        .load      (load),
        .line      (drain_line),
        .w         (w),
        .w_valid   (w_valid),
        .w_ready   (w_ready),
        .burst_done(burst_done)
    );

endmodule

`default_nettype wire

//--- sim/write_buffer_sva.sv
/* AXI write protocol checks for write_buffer, all disabled during reset */
`default_nettype none

module write_buffer_sva (
    input wire logic            clk,
    input wire logic            rstn,
    input wire wb_pkg::axi_aw_t aw,
    input wire logic            aw_valid,
    input wire logic            aw_ready,
    input wire wb_pkg::axi_w_t  w,
    input wire logic            w_valid,
    input wire logic            w_ready,
    input wire logic            b_ready,
    input wire logic            wrt_lock,
    input wire logic            load
);
    timeunit 1ns;
    timeprecision 100ps;

    // payload holds while the slave stalls
    aw_stable: assert property (@(posedge clk) disable iff (!rstn)
        aw_valid && !aw_ready |=> aw_valid && $stable(aw))
        else $error("AW payload changed under stall");

    w_stable: assert property (@(posedge clk) disable iff (!rstn)
        w_valid && !w_ready |=> w_valid && $stable(w))
        else $error("W payload changed under stall");

    lock_held: assert property (@(posedge clk) disable iff (!rstn)
        aw_valid || w_valid || b_ready |-> wrt_lock)
        else $error("AXI activity without wrt_lock");

    // the burst ends on last, and only a load starts another
    no_beat_after_last: assert property (@(posedge clk) disable iff (!rstn)
        w_valid && w_ready && w.last && !load |=> !w_valid)
        else $error("W beat after last");

    beat_needs_load: assert property (@(posedge clk) disable iff (!rstn)
        $rose(w_valid) |-> $past(load))
        else $error("w_valid rose without a load");

endmodule

`default_nettype wire

//--- sim/tb_write_buffer.sv
/* random traffic testbench for write_buffer, checked against a queue model every cycle.
   the AXI responder returns one B per burst and never reorders */
`default_nettype none

module tb_write_buffer;
    timeunit 1ns;
    timeprecision 100ps;

    import wb_pkg::*;

    localparam int DEPTH        = 5;
    localparam int OFFSET_WIDTH = 3;
    localparam int WORDS        = 2 ** OFFSET_WIDTH;
    localparam int LINE_W       = 32 * WORDS;
    localparam int LINE_BYTES   = 4 * WORDS;
    localparam int RESET_CYCLES = 4;
    localparam int PHASE_CYCLES = 500;
    localparam int DRAIN_BUDGET = 400;
    localparam int TOTAL_CYCLES = RESET_CYCLES + 4 * PHASE_CYCLES + DRAIN_BUDGET;

    typedef struct packed {
        addr_t             addr;
        logic [LINE_W-1:0] line;
    } entry_t;

    logic              clk = 1'b0;
    logic              rstn;
    logic              in_valid;
    addr_t             in_addr;
    logic [LINE_W-1:0] in_line;
    logic              in_ready;
    addr_t             query_addr;
    logic              query_hit;
    logic [LINE_W-1:0] query_line;
    logic              dma_lock;
    logic              wrt_lock;
    axi_aw_t           aw;
    logic              aw_valid;
    logic              aw_ready;
    axi_w_t            w;
    logic              w_valid;
    logic              w_ready;
    logic              b_valid;
    logic              b_ready;

    int     seed = 32'hbfd4;
    int     p_in;
    int     p_ready;
    int     p_lock;
    int     lock_left = 0;
    int     errors = 0;
    int     checks = 0;
    int     pushes = 0;
    int     drains = 0;
    int     beats = 0;
    bit     hs_in = 1'b0;
    bit     hs_b = 1'b0;
    bit     resp_pending = 1'b0;
    bit     draining = 1'b0;
    bit     aw_prev = 1'b0;
    bit     dma_prev = 1'b0;
    entry_t model[$];

    write_buffer #(.DEPTH(DEPTH), .OFFSET_WIDTH(OFFSET_WIDTH)) write_buffer_i (.*);

    bind write_buffer write_buffer_sva write_buffer_sva_i (
        .clk     (clk),
        .rstn    (rstn),
        .aw      (aw),
        .aw_valid(aw_valid),
        .aw_ready(aw_ready),
        .w       (w),
        .w_valid (w_valid),
        .w_ready (w_ready),
        .b_ready (b_ready),
        .wrt_lock(wrt_lock),
        .load    (load)
    );

    always #5 clk = ~clk;

    function automatic bit chance(input int pct);
        return ($unsigned($random(seed)) % 100) < pct;
    endfunction

    // six pushed addresses, the seventh is only ever queried
    function automatic addr_t pool_addr(input int n);
        return addr_t'(32'h1000_0000 + n * LINE_BYTES);
    endfunction

    function automatic logic [LINE_W-1:0] rand_line();
        logic [LINE_W-1:0] l;
        for (int k = 0; k < WORDS; k++) begin
            l[k*32 +: 32] = $random(seed);
        end
        return l;
    endfunction

    task automatic check_val(input string name, input logic [LINE_W-1:0] got,
                             input logic [LINE_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t %s got %h exp %h", $time, name, got, exp);
        end
    endtask

    task automatic drive_cycle();
        if (hs_in || !in_valid) begin
            in_valid <= chance(p_in);
            in_addr  <= pool_addr(int'($unsigned($random(seed)) % 6));
            in_line  <= rand_line();
        end
        query_addr <= pool_addr(int'($unsigned($random(seed)) % 7));
        if (lock_left > 0) begin
            lock_left--;
        end else if (chance(p_lock)) begin
            lock_left = 1 + int'($unsigned($random(seed)) % 8);
        end
        dma_lock <= (lock_left > 0);
        aw_ready <= chance(p_ready);
        w_ready  <= chance(p_ready);
        // b_valid stays up until its handshake
        if (hs_b) begin
            b_valid <= 1'b0;
        end else if (!b_valid) begin
            b_valid <= resp_pending && chance(p_ready);
        end
    endtask

    task automatic run_phase(input string name, input int pin, input int pready, input int plock);
        p_in    = pin;
        p_ready = pready;
        p_lock  = plock;
        repeat (PHASE_CYCLES) begin
            @(posedge clk);
            drive_cycle();
        end
        $display("phase %s: %0d cycles, %0d errors so far", name, PHASE_CYCLES, errors);
    endtask

    // sampled at the falling edge, handshakes complete on the next rising edge
    always @(negedge clk) begin : monitor
        bit                exp_hit;
        logic [LINE_W-1:0] exp_line;
        entry_t            head;
        if (rstn) begin
            check_val("in_ready", LINE_W'(in_ready), LINE_W'(model.size() < DEPTH));
            exp_hit  = 1'b0;
            exp_line = '0;
            for (int i = 0; i < model.size(); i++) begin
                if (model[i].addr == query_addr) begin
                    exp_hit  = 1'b1;
                    exp_line = model[i].line;
                end
            end
            check_val("query_hit", LINE_W'(query_hit), LINE_W'(exp_hit));
            check_val("query_line", query_line, exp_line);
            if (aw_valid && !aw_prev && dma_prev) begin
                errors++;
                $display("aw_valid rose at %0t right after a cycle with dma_lock high", $time);
            end
            if (aw_valid && !aw_prev) begin
                draining = 1'b1;
            end
            if (draining) begin
                check_val("wrt_lock", LINE_W'(wrt_lock), LINE_W'(1));
            end
            head = (model.size() != 0) ? model[0] : '0;
            if (aw_valid && aw_ready) begin
                if (model.size() == 0) begin
                    errors++;
                    $display("AW handshake at %0t while nothing is buffered", $time);
                end
                check_val("aw.addr", LINE_W'(aw.addr), LINE_W'(head.addr));
                check_val("aw.len", LINE_W'(aw.len), LINE_W'(WORDS - 1));
                beats = 0;
            end
            if (w_valid && w_ready) begin
                if (!draining) begin
                    errors++;
                    $display("W beat at %0t outside of a drain", $time);
                end
                check_val("w.data", LINE_W'(w.data), LINE_W'(head.line[beats*32 +: 32]));
                check_val("w.last", LINE_W'(w.last), LINE_W'(beats == WORDS - 1));
                resp_pending = resp_pending || w.last;
                beats++;
            end
            if (b_valid && b_ready) begin
                check_val("beat count", LINE_W'(beats), LINE_W'(WORDS));
                if (model.size() == 0) begin
                    errors++;
                    $display("B handshake at %0t while nothing is buffered", $time);
                end else begin
                    void'(model.pop_front());
                    drains++;
                end
                draining     = 1'b0;
                resp_pending = 1'b0;
            end
            hs_b  = b_valid && b_ready;
            hs_in = in_valid && in_ready;
            if (hs_in) begin
                model.push_back(entry_t'{addr: in_addr, line: in_line});
                pushes++;
            end
            aw_prev  = aw_valid;
            dma_prev = dma_lock;
        end
    end

    initial begin
        int n;
        rstn       = 1'b0;
        in_valid   = 1'b0;
        in_addr    = '0;
        in_line    = '0;
        query_addr = '0;
        dma_lock   = 1'b0;
        aw_ready   = 1'b0;
        w_ready    = 1'b0;
        b_valid    = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rstn <= 1'b1;
        @(negedge clk);
        check_val("in_ready", LINE_W'(in_ready), LINE_W'(1));
        check_val("query_hit", LINE_W'(query_hit), LINE_W'(0));
        check_val("aw_valid", LINE_W'(aw_valid), LINE_W'(0));
        check_val("w_valid", LINE_W'(w_valid), LINE_W'(0));
        check_val("b_ready", LINE_W'(b_ready), LINE_W'(0));
        check_val("wrt_lock", LINE_W'(wrt_lock), LINE_W'(0));
        $display("phase reset: %0d errors so far", errors);
        run_phase("light", 30, 80, 0);
        run_phase("full", 90, 20, 0);
        run_phase("dma", 50, 60, 10);
        run_phase("mixed", 60, 45, 4);
        // empty out whatever is still queued
        p_in    = 0;
        p_ready = 100;
        p_lock  = 0;
        n       = 0;
        while (model.size() != 0 || draining || in_valid) begin
            @(posedge clk);
            drive_cycle();
            n++;
        end
        $display("phase drain: %0d cycles, %0d errors so far", n, errors);
        $display("checks %0d, errors %0d, pushes %0d, drains %0d", checks, errors, pushes, drains);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin
        #(2 * TOTAL_CYCLES * 10);
        $display("timeout: run did not finish within %0d cycles", 2 * TOTAL_CYCLES);
        $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
design/wb_pkg.sv
design/wb_queue.sv
design/wb_drain_ctrl.sv
design/wb_beat_serializer.sv
design/write_buffer.sv
sim/write_buffer_sva.sv
sim/tb_write_buffer.sv

//--- run.sh
#!/bin/sh
# build and run the write buffer testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_write_buffer -f files.f
status=0
out=$(./obj_dir/Vtb_write_buffer) || status=$?
echo "$out"
if echo "$out" | grep -qx "TB PASSED"; then
    exit 0
fi
echo "simulation did not pass, exit status $status"
exit 1
